/* hdl/cluster_defs.svh */
`ifndef CLUSTER_DEFS_SVH
`define CLUSTER_DEFS_SVH

// Cluster shape
`define NUM_CORES       2
`define NUM_MEM_PORTS   (2 * `NUM_CORES)
`define PORT_SEL_BITS   2
`define CORE_ID_BITS    1

// Refill line geometry
`define LINE_WIDTH      64
`define BYTEEN_WIDTH    8
`define MEM_ADDR_WIDTH  26

// Port index sits above the core tag on the DRAM side
`define CORE_TAG_WIDTH  4
`define DRAM_TAG_WIDTH  (`CORE_TAG_WIDTH + `PORT_SEL_BITS)

// Host CSR access
`define CSR_ADDR_WIDTH  12
`define CSR_DATA_WIDTH  32

`endif

/* hdl/cluster_pkg.sv */
`default_nettype none

`include "cluster_defs.svh"

package cluster_pkg;

    typedef struct packed {
        logic                        rw;
        logic [`BYTEEN_WIDTH-1:0]    byteen;
        logic [`MEM_ADDR_WIDTH-1:0]  addr;
        logic [`LINE_WIDTH-1:0]      data;
        logic [`CORE_TAG_WIDTH-1:0]  tag;
    } mem_req_t;

    typedef struct packed {
        logic [`LINE_WIDTH-1:0]      data;
        logic [`CORE_TAG_WIDTH-1:0]  tag;
    } mem_rsp_t;

    typedef struct packed {
        logic                        rw;
        logic [`BYTEEN_WIDTH-1:0]    byteen;
        logic [`MEM_ADDR_WIDTH-1:0]  addr;
        logic [`LINE_WIDTH-1:0]      data;
        logic [`DRAM_TAG_WIDTH-1:0]  tag;
    } dram_req_t;

    typedef struct packed {
        logic [`LINE_WIDTH-1:0]      data;
        logic [`DRAM_TAG_WIDTH-1:0]  tag;
    } dram_rsp_t;

    typedef struct packed {
        logic [`CSR_ADDR_WIDTH-1:0]  addr;
        logic                        rw;
        logic [`CSR_DATA_WIDTH-1:0]  data;
    } csr_req_t;

    typedef struct packed {
        logic [`CSR_DATA_WIDTH-1:0]  data;
    } csr_rsp_t;

    // Refill port index is 2 * core + this
    typedef enum logic {
        PORT_DCACHE = 1'b0,
        PORT_ICACHE = 1'b1
    } mem_port_e;

    typedef enum logic {
        CSR_IDLE     = 1'b0,
        CSR_WAIT_RSP = 1'b1
    } csr_state_e;

endpackage

`default_nettype wire

/* hdl/dram_req_arb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cluster_defs.svh"

module dram_req_arb
    import cluster_pkg::*;
(
    input  wire                                 clk,
    input  wire                                 reset,

    // Refill requests from all ports
    input  wire [`NUM_MEM_PORTS-1:0]            in_valid,
    input  wire mem_req_t [`NUM_MEM_PORTS-1:0]  in_req,
    output logic [`NUM_MEM_PORTS-1:0]           in_ready,

    // DRAM request
    output logic                                dram_req_valid,
    output dram_req_t                           dram_req,
    input  wire                                 dram_req_ready
);

    logic [`PORT_SEL_BITS-1:0] rr_ptr;
    logic [`PORT_SEL_BITS-1:0] grant_idx;
    logic                      grant_found;
    logic                      load;
    logic                      take;
    mem_req_t                  win_req;

    // Output register is free or drains this cycle
    assign load = !dram_req_valid || dram_req_ready;
    assign take = load && grant_found;

    // First valid port at or after the pointer
    always_comb begin
        int unsigned cand;
        grant_found = 1'b0;
        grant_idx   = '0;
        for (int i = `NUM_MEM_PORTS - 1; i >= 0; i--) begin
            cand = (rr_ptr + i) % `NUM_MEM_PORTS;
            if (in_valid[cand]) begin
                grant_found = 1'b1;
                grant_idx   = cand[`PORT_SEL_BITS-1:0];
            end
        end
    end

    always_comb begin
        in_ready            = '0;
        in_ready[grant_idx] = take;
    end

    assign win_req = in_req[grant_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            dram_req_valid <= 1'b0;
            rr_ptr         <= '0;
        end else begin
            if (load) begin
                dram_req_valid <= grant_found;
            end
            if (take) begin
                // Pointer moves just past the winner
                if (grant_idx == `NUM_MEM_PORTS - 1) begin
                    rr_ptr <= '0;
                end else begin
                    rr_ptr <= grant_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            dram_req.rw     <= win_req.rw;
            dram_req.byteen <= win_req.byteen;
            dram_req.addr   <= win_req.addr;
            dram_req.data   <= win_req.data;
            // Source port goes above the core tag
            dram_req.tag    <= {grant_idx, win_req.tag};
        end
    end

endmodule

`default_nettype wire

/* hdl/dram_rsp_router.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cluster_defs.svh"

module dram_rsp_router
    import cluster_pkg::*;
(
    // DRAM response
    input  wire                                 dram_rsp_valid,
    input  wire dram_rsp_t                      dram_rsp,
    output logic                                dram_rsp_ready,

    // Per-port refill responses
    output logic [`NUM_MEM_PORTS-1:0]           out_valid,
    output mem_rsp_t [`NUM_MEM_PORTS-1:0]       out_rsp,
    input  wire [`NUM_MEM_PORTS-1:0]            out_ready
);

    logic [`PORT_SEL_BITS-1:0]  rsp_port;
    logic [`CORE_TAG_WIDTH-1:0] rsp_tag;

    // Upper tag bits name the port, lower bits go back to the core
    assign rsp_port = dram_rsp.tag[`DRAM_TAG_WIDTH-1 -: `PORT_SEL_BITS];
    assign rsp_tag  = dram_rsp.tag[`CORE_TAG_WIDTH-1:0];

    always_comb begin
        out_valid           = '0;
        out_valid[rsp_port] = dram_rsp_valid;
    end

    // Payload is broadcast, only valid is steered
    always_comb begin
        for (int i = 0; i < `NUM_MEM_PORTS; i++) begin
            out_rsp[i].data = dram_rsp.data;
            out_rsp[i].tag  = rsp_tag;
        end
    end

    assign dram_rsp_ready = out_ready[rsp_port];

endmodule

`default_nettype wire

/* hdl/csr_io_router.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cluster_defs.svh"

module csr_io_router
    import cluster_pkg::*;
(
    input  wire                                 clk,
    input  wire                                 reset,

    // Host request
    input  wire                                 host_req_valid,
    input  wire [`CORE_ID_BITS-1:0]             host_coreid,
    input  wire csr_req_t                       host_req,
    output logic                                host_req_ready,

    // Host response
    output logic                                host_rsp_valid,
    output csr_rsp_t                            host_rsp,
    input  wire                                 host_rsp_ready,

    // Request to the cores
    output logic [`NUM_CORES-1:0]               core_req_valid,
    output csr_req_t                            core_req,
    input  wire [`NUM_CORES-1:0]                core_req_ready,

    // Response from the cores
    input  wire [`NUM_CORES-1:0]                core_rsp_valid,
    input  wire csr_rsp_t [`NUM_CORES-1:0]      core_rsp,
    output logic [`NUM_CORES-1:0]               core_rsp_ready
);

    csr_state_e               state;
    logic [`CORE_ID_BITS-1:0] sel_core;

    // Same request seen by every core, valid picks the target
    assign core_req = host_req;
    assign host_rsp = core_rsp[sel_core];

    always_comb begin
        host_req_ready = 1'b0;
        host_rsp_valid = 1'b0;
        core_req_valid = '0;
        core_rsp_ready = '0;
        case (state)
            CSR_IDLE: begin
                core_req_valid[host_coreid] = host_req_valid;
                host_req_ready              = core_req_ready[host_coreid];
            end
            CSR_WAIT_RSP: begin
                // Only the addressed core may answer
                host_rsp_valid           = core_rsp_valid[sel_core];
                core_rsp_ready[sel_core] = host_rsp_ready;
            end
            default: begin
                host_req_ready = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= CSR_IDLE;
            sel_core <= '0;
        end else begin
            case (state)
                CSR_IDLE: begin
                    if (host_req_valid && host_req_ready) begin
                        sel_core <= host_coreid;
                        state    <= CSR_WAIT_RSP;
                    end
                end
                CSR_WAIT_RSP: begin
                    if (host_rsp_valid && host_rsp_ready) begin
                        state <= CSR_IDLE;
                    end
                end
                default: state <= CSR_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/cluster_uncore.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cluster_defs.svh"

module cluster_uncore
    import cluster_pkg::*;
(
    input  wire                                 clk,
    input  wire                                 reset,

    // Data cache refill
    input  wire [`NUM_CORES-1:0]                core_dcache_req_valid,
    input  wire mem_req_t [`NUM_CORES-1:0]      core_dcache_req,
    output wire [`NUM_CORES-1:0]                core_dcache_req_ready,
    output wire [`NUM_CORES-1:0]                core_dcache_rsp_valid,
    output wire mem_rsp_t [`NUM_CORES-1:0]      core_dcache_rsp,
    input  wire [`NUM_CORES-1:0]                core_dcache_rsp_ready,

    // Instruction cache refill
    input  wire [`NUM_CORES-1:0]                core_icache_req_valid,
    input  wire mem_req_t [`NUM_CORES-1:0]      core_icache_req,
    output wire [`NUM_CORES-1:0]                core_icache_req_ready,
    output wire [`NUM_CORES-1:0]                core_icache_rsp_valid,
    output wire mem_rsp_t [`NUM_CORES-1:0]      core_icache_rsp,
    input  wire [`NUM_CORES-1:0]                core_icache_rsp_ready,

    // DRAM
    output wire                                 dram_req_valid,
    output wire dram_req_t                      dram_req,
    input  wire                                 dram_req_ready,
    input  wire                                 dram_rsp_valid,
    input  wire dram_rsp_t                      dram_rsp,
    output wire                                 dram_rsp_ready,

    // Host CSR
    input  wire                                 csr_io_req_valid,
    input  wire [`CORE_ID_BITS-1:0]             csr_io_req_coreid,
    input  wire csr_req_t                       csr_io_req,
    output wire                                 csr_io_req_ready,
    output wire                                 csr_io_rsp_valid,
    output wire csr_rsp_t                       csr_io_rsp,
    input  wire                                 csr_io_rsp_ready,

    // Core CSR
    output wire [`NUM_CORES-1:0]                core_csr_req_valid,
    output wire csr_req_t                       core_csr_req,
    input  wire [`NUM_CORES-1:0]                core_csr_req_ready,
    input  wire [`NUM_CORES-1:0]                core_csr_rsp_valid,
    input  wire csr_rsp_t [`NUM_CORES-1:0]      core_csr_rsp,
    output wire [`NUM_CORES-1:0]                core_csr_rsp_ready,

    // Status
    input  wire [`NUM_CORES-1:0]                core_busy,
    input  wire [`NUM_CORES-1:0]                core_ebreak,
    output wire                                 busy,
    output wire                                 ebreak
);

    wire [`NUM_MEM_PORTS-1:0]             arb_valid;
    wire mem_req_t [`NUM_MEM_PORTS-1:0]   arb_req;
    wire [`NUM_MEM_PORTS-1:0]             arb_ready;
    wire [`NUM_MEM_PORTS-1:0]             rtr_valid;
    wire mem_rsp_t [`NUM_MEM_PORTS-1:0]   rtr_rsp;
    wire [`NUM_MEM_PORTS-1:0]             rtr_ready;

    // Data and instruction ports of a core sit side by side
    for (genvar i = 0; i < `NUM_CORES; i++) begin : g_port
        localparam int DC = 2 * i + int'(PORT_DCACHE);
        localparam int IC = 2 * i + int'(PORT_ICACHE);

        assign arb_valid[DC]            = core_dcache_req_valid[i];
        assign arb_req[DC]              = core_dcache_req[i];
        assign core_dcache_req_ready[i] = arb_ready[DC];
        assign core_dcache_rsp_valid[i] = rtr_valid[DC];
        assign core_dcache_rsp[i]       = rtr_rsp[DC];
        assign rtr_ready[DC]            = core_dcache_rsp_ready[i];

        assign arb_valid[IC]            = core_icache_req_valid[i];
        assign arb_req[IC]              = core_icache_req[i];
        assign core_icache_req_ready[i] = arb_ready[IC];
        assign core_icache_rsp_valid[i] = rtr_valid[IC];
        assign core_icache_rsp[i]       = rtr_rsp[IC];
        assign rtr_ready[IC]            = core_icache_rsp_ready[i];
    end

    dram_req_arb dram_req_arb_i (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (arb_valid),
        .in_req         (arb_req),
        .in_ready       (arb_ready),
        .dram_req_valid (dram_req_valid),
        .dram_req       (dram_req),
        .dram_req_ready (dram_req_ready)
    );

    dram_rsp_router dram_rsp_router_i (
        .dram_rsp_valid (dram_rsp_valid),
        .dram_rsp       (dram_rsp),
        .dram_rsp_ready (dram_rsp_ready),
        .out_valid      (rtr_valid),
        .out_rsp        (rtr_rsp),
        .out_ready      (rtr_ready)
    );

    csr_io_router csr_io_router_i (
        .clk            (clk),
        .reset          (reset),
        .host_req_valid (csr_io_req_valid),
        .host_coreid    (csr_io_req_coreid),
        .host_req       (csr_io_req),
        .host_req_ready (csr_io_req_ready),
        .host_rsp_valid (csr_io_rsp_valid),
        .host_rsp       (csr_io_rsp),
        .host_rsp_ready (csr_io_rsp_ready),
        .core_req_valid (core_csr_req_valid),
        .core_req       (core_csr_req),
        .core_req_ready (core_csr_req_ready),
        .core_rsp_valid (core_csr_rsp_valid),
        .core_rsp       (core_csr_rsp),
        .core_rsp_ready (core_csr_rsp_ready)
    );

    // Any core busy, all cores halted
    assign busy   = |core_busy;
    assign ebreak = &core_ebreak;

endmodule

`default_nettype wire

/* tb/cluster_tb_clk.sv */
`timescale 1ns/10ps
`default_nettype none

module cluster_tb_clk (
    output logic clk
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* tb/cluster_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cluster_defs.svh"

module cluster_tb
    import cluster_pkg::*;
();

    localparam int NP = `NUM_MEM_PORTS;
    localparam int NC = `NUM_CORES;
    // Roughly four times the summed length of all tests
    localparam int MAX_CYCLES = 20000;

    wire  clk;
    logic reset;

    // Refill ports seen by index 2 * core + mem_port_e
    logic [NP-1:0]          req_valid;
    mem_req_t [NP-1:0]      req_data;
    wire [NP-1:0]           req_ready;
    wire [NP-1:0]           rsp_valid;
    wire mem_rsp_t [NP-1:0] rsp_data;
    logic [NP-1:0]          rsp_ready;

    wire [NC-1:0]           core_dcache_req_valid;
    wire mem_req_t [NC-1:0] core_dcache_req;
    wire [NC-1:0]           core_dcache_req_ready;
    wire [NC-1:0]           core_dcache_rsp_valid;
    wire mem_rsp_t [NC-1:0] core_dcache_rsp;
    wire [NC-1:0]           core_dcache_rsp_ready;
    wire [NC-1:0]           core_icache_req_valid;
    wire mem_req_t [NC-1:0] core_icache_req;
    wire [NC-1:0]           core_icache_req_ready;
    wire [NC-1:0]           core_icache_rsp_valid;
    wire mem_rsp_t [NC-1:0] core_icache_rsp;
    wire [NC-1:0]           core_icache_rsp_ready;

    wire                    dram_req_valid;
    wire dram_req_t         dram_req;
    logic                   dram_req_ready;
    logic                   dram_rsp_valid;
    dram_rsp_t              dram_rsp;
    wire                    dram_rsp_ready;

    logic                      csr_io_req_valid;
    logic [`CORE_ID_BITS-1:0]  csr_io_req_coreid;
    csr_req_t                  csr_io_req;
    wire                       csr_io_req_ready;
    wire                       csr_io_rsp_valid;
    wire csr_rsp_t             csr_io_rsp;
    logic                      csr_io_rsp_ready;
    wire [NC-1:0]              core_csr_req_valid;
    wire csr_req_t             core_csr_req;
    logic [NC-1:0]             core_csr_req_ready;
    logic [NC-1:0]             core_csr_rsp_valid;
    csr_rsp_t [NC-1:0]         core_csr_rsp;
    wire [NC-1:0]              core_csr_rsp_ready;

    logic [NC-1:0]          core_busy;
    logic [NC-1:0]          core_ebreak;
    wire                    busy;
    wire                    ebreak;

    // Expected DRAM requests per source port, in issue order
    dram_req_t                sb [NP][$];
    int                       window [$];
    bit                       fair_mode = 1'b0;
    bit                       held = 1'b0;
    dram_req_t                held_req;
    bit                       csr_pending = 1'b0;
    logic [`CORE_ID_BITS-1:0] csr_core;
    logic [`CSR_DATA_WIDTH-1:0] csr_exp_data;
    int                       errors = 0;
    int                       cycle_count = 0;

    for (genvar c = 0; c < NC; c++) begin : g_map
        localparam int DC = 2 * c + int'(PORT_DCACHE);
        localparam int IC = 2 * c + int'(PORT_ICACHE);

        assign core_dcache_req_valid[c] = req_valid[DC];
        assign core_dcache_req[c]       = req_data[DC];
        assign req_ready[DC]            = core_dcache_req_ready[c];
        assign rsp_valid[DC]            = core_dcache_rsp_valid[c];
        assign rsp_data[DC]             = core_dcache_rsp[c];
        assign core_dcache_rsp_ready[c] = rsp_ready[DC];

        assign core_icache_req_valid[c] = req_valid[IC];
        assign core_icache_req[c]       = req_data[IC];
        assign req_ready[IC]            = core_icache_req_ready[c];
        assign rsp_valid[IC]            = core_icache_rsp_valid[c];
        assign rsp_data[IC]             = core_icache_rsp[c];
        assign core_icache_rsp_ready[c] = rsp_ready[IC];
    end

    cluster_tb_clk clk_gen_i (
        .clk (clk)
    );

    cluster_uncore cluster_uncore_i (.*);

    task automatic stop_with_error(input string why);
        errors++;
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare(input string name, input logic [127:0] expected,
                           input logic [127:0] actual);
        if (expected !== actual) begin
            stop_with_error($sformatf("FAILED %s expected %h actual %h",
                                      name, expected, actual));
        end
    endtask

    // Port index goes above the core tag
    function automatic dram_req_t expect_dram_req(input mem_req_t req, input int port);
        dram_req_t exp;
        exp.rw     = req.rw;
        exp.byteen = req.byteen;
        exp.addr   = req.addr;
        exp.data   = req.data;
        exp.tag    = port * (1 << `CORE_TAG_WIDTH) + req.tag;
        return exp;
    endfunction

    function automatic int expect_port(input logic [`DRAM_TAG_WIDTH-1:0] tag);
        return tag / (1 << `CORE_TAG_WIDTH);
    endfunction

    function automatic mem_rsp_t expect_core_rsp(input dram_rsp_t rsp);
        mem_rsp_t exp;
        exp.data = rsp.data;
        exp.tag  = rsp.tag % (1 << `CORE_TAG_WIDTH);
        return exp;
    endfunction

    function automatic logic [NC-1:0] expect_csr_route(input logic [`CORE_ID_BITS-1:0] id,
                                                       input logic en);
        logic [NC-1:0] sel;
        sel     = '0;
        sel[id] = en;
        return sel;
    endfunction

    // busy is any core busy, ebreak needs every core
    function automatic logic [1:0] expect_status(input logic [NC-1:0] busy_v,
                                                 input logic [NC-1:0] ebreak_v);
        return {busy_v != '0, ebreak_v == {NC{1'b1}}};
    endfunction

    function automatic mem_req_t random_req();
        mem_req_t r;
        r.rw     = $urandom_range(1, 0);
        r.byteen = $urandom;
        r.addr   = $urandom;
        r.data   = {$urandom, $urandom};
        r.tag    = $urandom_range((1 << `CORE_TAG_WIDTH) - 1, 0);
        return r;
    endfunction

    function automatic bit sb_empty();
        for (int p = 0; p < NP; p++) begin
            if (sb[p].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic issue_requests(input int per_port, input bit keep_valid,
                                  input bit random_ready);
        int left [NP];
        bit on [NP];
        bit active;
        for (int p = 0; p < NP; p++) begin
            left[p] = per_port;
            on[p]   = 1'b0;
        end
        active = 1'b1;
        while (active) begin
            @(posedge clk);
            active = 1'b0;
            for (int p = 0; p < NP; p++) begin
                if (!on[p] || req_ready[p]) begin
                    if (left[p] > 0 && (keep_valid || $urandom_range(1, 0) == 1)) begin
                        req_valid[p] <= 1'b1;
                        req_data[p]  <= random_req();
                        on[p] = 1'b1;
                        left[p]--;
                    end else begin
                        req_valid[p] <= 1'b0;
                        on[p] = 1'b0;
                    end
                end
                if (left[p] > 0 || on[p]) begin
                    active = 1'b1;
                end
            end
            dram_req_ready <= random_ready ? ($urandom_range(1, 0) == 1) : 1'b1;
        end
    endtask

    task automatic drain_dram(input string test);
        int n;
        @(posedge clk);
        dram_req_ready <= 1'b1;
        n = 0;
        @(negedge clk);
        while ((!sb_empty() || dram_req_valid) && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!sb_empty() || dram_req_valid) begin
            stop_with_error({"Request lost or stuck at DRAM after the ", test, " test"});
        end
    endtask

    task automatic route_responses(input int count);
        dram_rsp_t rsp;
        int sent;
        bit on;
        sent = 0;
        on   = 1'b0;
        while (sent < count || on) begin
            @(posedge clk);
            rsp_ready <= $urandom_range((1 << NP) - 1, 0);
            if (!on || dram_rsp_ready) begin
                if (sent < count) begin
                    rsp.data = {$urandom, $urandom};
                    rsp.tag  = $urandom_range((1 << `DRAM_TAG_WIDTH) - 1, 0);
                    dram_rsp_valid <= 1'b1;
                    dram_rsp       <= rsp;
                    on = 1'b1;
                    sent++;
                end else begin
                    dram_rsp_valid <= 1'b0;
                    on = 1'b0;
                end
            end
        end
        rsp_ready <= '0;
    endtask

    task automatic steer_csr(input int count);
        logic [`CORE_ID_BITS-1:0] id;
        logic [`CORE_ID_BITS-1:0] other;
        csr_req_t req;
        for (int k = 0; k < count; k++) begin
            id       = $urandom_range(NC - 1, 0);
            other    = (id + 1) % NC;
            req.addr = $urandom;
            req.rw   = $urandom_range(1, 0);
            req.data = $urandom;
            @(posedge clk);
            csr_io_req_valid  <= 1'b1;
            csr_io_req_coreid <= id;
            csr_io_req        <= req;
            do begin
                @(posedge clk);
                core_csr_req_ready <= $urandom_range((1 << NC) - 1, 0);
            end while (!(csr_io_req_valid && csr_io_req_ready));
            csr_io_req_valid   <= 1'b0;
            // Cores stay ready while the access is outstanding
            core_csr_req_ready <= '1;
            // Decoy answer from a core that was not asked
            core_csr_rsp_valid[other] <= 1'b1;
            core_csr_rsp[other].data  <= ~req.data;
            csr_io_rsp_ready          <= 1'b1;
            repeat (2) @(posedge clk);
            csr_exp_data = $urandom;
            core_csr_rsp_valid[id] <= 1'b1;
            core_csr_rsp[id].data  <= csr_exp_data;
            csr_io_rsp_ready       <= ($urandom_range(1, 0) == 1);
            do begin
                @(posedge clk);
                csr_io_rsp_ready <= ($urandom_range(1, 0) == 1);
            end while (!(csr_io_rsp_valid && csr_io_rsp_ready));
            core_csr_rsp_valid <= '0;
            core_csr_req_ready <= '0;
            csr_io_rsp_ready   <= 1'b0;
        end
    endtask

    task automatic drive_status(input int count);
        for (int k = 0; k < count; k++) begin
            @(posedge clk);
            core_busy   <= $urandom_range((1 << NC) - 1, 0);
            core_ebreak <= $urandom_range((1 << NC) - 1, 0);
        end
        @(posedge clk);
    endtask

    // Comparison process
    always @(posedge clk) begin
        int port;
        logic [NP-1:0] mask;
        if (!reset) begin
            for (int p = 0; p < NP; p++) begin
                if (req_valid[p] && req_ready[p]) begin
                    sb[p].push_back(expect_dram_req(req_data[p], p));
                end
            end
            if (held) begin
                compare("dram_req_valid held", 1'b1, dram_req_valid);
                compare("dram_req held", held_req, dram_req);
            end
            held     = dram_req_valid && !dram_req_ready;
            held_req = dram_req;
            if (dram_req_valid && dram_req_ready) begin
                port = expect_port(dram_req.tag);
                if (sb[port].size() == 0) begin
                    stop_with_error($sformatf("DRAM request for port %0d was never issued", port));
                end else begin
                    compare("dram_req", sb[port].pop_front(), dram_req);
                end
                if (fair_mode) begin
                    window.push_back(port);
                    if (window.size() > NP) begin
                        void'(window.pop_front());
                    end
                    if (window.size() == NP) begin
                        mask = '0;
                        foreach (window[w]) begin
                            mask[window[w]] = 1'b1;
                        end
                        compare("fairness window", {NP{1'b1}}, mask);
                    end
                end
            end
            if (!fair_mode) begin
                window.delete();
            end

            if (dram_rsp_valid) begin
                port = expect_port(dram_rsp.tag);
                compare("rsp_valid", 1 << port, rsp_valid);
                compare("dram_rsp_ready", rsp_ready[port], dram_rsp_ready);
                compare("rsp_data", expect_core_rsp(dram_rsp), rsp_data[port]);
            end else begin
                compare("rsp_valid idle", '0, rsp_valid);
            end

            compare("core_csr_req_valid",
                    expect_csr_route(csr_io_req_coreid, csr_io_req_valid && !csr_pending),
                    core_csr_req_valid);
            if (csr_pending) begin
                compare("csr_io_req_ready", 1'b0, csr_io_req_ready);
                compare("core_csr_rsp_ready", expect_csr_route(csr_core, csr_io_rsp_ready),
                        core_csr_rsp_ready);
                if (csr_io_rsp_valid && !core_csr_rsp_valid[csr_core]) begin
                    stop_with_error("CSR response passed on from a core that was not addressed");
                end
                if (core_csr_rsp_valid[csr_core]) begin
                    compare("csr_io_rsp_valid", 1'b1, csr_io_rsp_valid);
                    compare("csr_io_rsp", csr_exp_data, csr_io_rsp);
                    if (csr_io_rsp_ready) begin
                        csr_pending = 1'b0;
                    end
                end
            end else begin
                compare("core_csr_rsp_ready idle", '0, core_csr_rsp_ready);
                if (csr_io_rsp_valid) begin
                    stop_with_error("CSR response seen with no access outstanding");
                end
                if (csr_io_req_valid) begin
                    compare("core_csr_req", csr_io_req, core_csr_req);
                    compare("csr_io_req_ready", core_csr_req_ready[csr_io_req_coreid],
                            csr_io_req_ready);
                    if (csr_io_req_ready) begin
                        csr_pending = 1'b1;
                        csr_core    = csr_io_req_coreid;
                    end
                end
            end

            compare("busy and ebreak", expect_status(core_busy, core_ebreak), {busy, ebreak});
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            stop_with_error($sformatf("Run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    initial begin
        void'($urandom(75));
        reset              = 1'b1;
        req_valid          = '0;
        req_data           = '0;
        rsp_ready          = '0;
        dram_req_ready     = 1'b0;
        dram_rsp_valid     = 1'b0;
        dram_rsp           = '0;
        csr_io_req_valid   = 1'b0;
        csr_io_req_coreid  = '0;
        csr_io_req         = '0;
        csr_io_rsp_ready   = 1'b0;
        core_csr_req_ready = '0;
        core_csr_rsp_valid = '0;
        core_csr_rsp       = '0;
        core_busy          = '0;
        core_ebreak        = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        compare("dram_req_valid after reset", 1'b0, dram_req_valid);
        compare("csr_io_rsp_valid after reset", 1'b0, csr_io_rsp_valid);
        compare("core_csr_req_valid after reset", '0, core_csr_req_valid);
        compare("rsp_valid after reset", '0, rsp_valid);

        issue_requests(150, 1'b0, 1'b0);
        drain_dram("forwarding");
        fair_mode = 1'b1;
        issue_requests(100, 1'b1, 1'b0);
        drain_dram("fairness");
        fair_mode = 1'b0;
        issue_requests(150, 1'b0, 1'b1);
        drain_dram("back-pressure");
        route_responses(500);
        steer_csr(100);
        drive_status(200);

        if (errors == 0 && sb_empty()) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
hdl/cluster_pkg.sv
hdl/dram_req_arb.sv
hdl/dram_rsp_router.sv
hdl/csr_io_router.sv
hdl/cluster_uncore.sv
tb/cluster_tb_clk.sv
tb/cluster_tb.sv

/* Bender.yml */
package:
  name: cluster_uncore

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cluster_pkg.sv
      - hdl/dram_req_arb.sv
      - hdl/dram_rsp_router.sv
      - hdl/csr_io_router.sv
      - hdl/cluster_uncore.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - tb/cluster_tb_clk.sv
      - tb/cluster_tb.sv
